//--- exc_pc_sel.sv
// ----------------------------------------------------------
// trap and debug entry address, purely combinational
// unknown exc_pc_mux values give the plain exception address
// ----------------------------------------------------------

module exc_pc_sel
  import if_ctrl_pkg::*, if_data_pkg::*;
(
  input  trap_cfg_t   trap_cfg_i,   // trap bases and vector ids
  input  trap_mux_e   trap_mux_i,   // machine or user vector
  input  exc_pc_mux_e exc_pc_mux_i, // kind of entry
  input  dbg_addr_t   dbg_addr_i,   // debug module entry points
  output addr_t       exc_pc_o
);

  logic [23:0] trap_base; // base of the selected vector table
  logic [4:0]  vec_idx;   // interrupt slot within the table

  // pick machine or user set, anything unknown falls back to machine
  always_comb begin
    case (trap_mux_i)
      TRAP_USER: begin
        trap_base = trap_cfg_i.u_base;
        vec_idx   = trap_cfg_i.u_vec;
      end
      default: begin
        trap_base = trap_cfg_i.m_base;
        vec_idx   = trap_cfg_i.m_vec;
      end
    endcase
  end

  // ----------------------------------------------------------
  // entry address
  // ----------------------------------------------------------
  always_comb begin
    case (exc_pc_mux_i)
      EXC_PC_IRQ: exc_pc_o = {trap_base, 1'b0, vec_idx, 2'b00}; // base + 4*id
      EXC_PC_DBD: exc_pc_o = {dbg_addr_i.halt[31:2], 2'b00};    // word aligned
      EXC_PC_DBE: exc_pc_o = {dbg_addr_i.exc[31:2], 2'b00};
      default:    exc_pc_o = {trap_base, 8'h00};                // all exceptions at base
    endcase
  end

endmodule

//--- fetch_pipe.sv
// ----------------------------------------------------------
// fetch accept, fetch pc and the single entry IF/ID register
// each offered word is assumed to start at pc_if_o
// ----------------------------------------------------------

module fetch_pipe
  import if_data_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,               // core wants instructions
  input  logic        pc_set_i,            // redirect, wins over accept
  input  logic        fetch_valid_i,       // source offers a word
  input  logic [31:0] fetch_rdata_i,       // offered word
  input  logic        id_ready_i,          // ID can take a new instruction
  input  logic        halt_if_i,           // controller freezes fetch
  input  logic        clear_instr_valid_i, // kill instruction in ID
  input  addr_t       branch_addr_i,       // redirect target
  output logic        fetch_ready_o,       // word taken this cycle
  output logic        branch_o,            // source must restart
  output logic        perf_imiss_o,        // cycle lost waiting on fetch
  output logic        instr_valid_id_o,
  output if_id_t      if_id_o,
  output addr_t       pc_if_o,             // address of the offered word
  output addr_t       pc_id_o              // address of the word in ID
);

  logic   accept;    // word moves into IF/ID
  logic   is_c;      // low bits not 2'b11
  logic   illegal_c; // compressed and all zero
  addr_t  pc_q;
  if_id_t if_id_q;
  logic   valid_q;

  // ----------------------------------------------------------
  // handshake with the fetch source
  // ----------------------------------------------------------
  assign accept = req_i & fetch_valid_i & id_ready_i & ~halt_if_i & ~pc_set_i;

  assign fetch_ready_o = accept;
  assign branch_o      = pc_set_i;                  // same cycle restart
  assign perf_imiss_o  = ~fetch_valid_i & ~pc_set_i; // redirect cycles not counted

  // length and illegal decode on the raw word
  assign is_c      = (fetch_rdata_i[1:0] != 2'b11);
  assign illegal_c = is_c & (fetch_rdata_i[15:0] == 16'h0000); // defined illegal

  // ----------------------------------------------------------
  // fetch pc
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= '0;
    end else if (pc_set_i) begin
      pc_q <= branch_addr_i;
    end else if (accept) begin
      pc_q <= is_c ? pc_q + 32'd2 : pc_q + 32'd4; // step over the taken word
    end
  end

  // ----------------------------------------------------------
  // IF/ID register, holds while ID stalls
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      if_id_q <= '0;
    end else if (accept) begin
      valid_q               <= 1'b1;
      if_id_q.instr         <= fetch_rdata_i; // passed on undecompressed
      if_id_q.pc            <= pc_q;
      if_id_q.is_compressed <= is_c;
      if_id_q.illegal_c     <= illegal_c;
    end else if (clear_instr_valid_i) begin
      valid_q <= 1'b0; // payload kept, only valid drops
    end
  end

  assign instr_valid_id_o = valid_q;
  assign if_id_o          = if_id_q;
  assign pc_if_o          = pc_q;
  assign pc_id_o          = if_id_q.pc; // used by fence.i redirect

endmodule

//--- if_ctrl_pkg.sv
// ----------------------------------------------------------
// select encodings for the fetch stage redirect and trap muxes
// trap mode values other than machine or user act as machine
// ----------------------------------------------------------

package if_ctrl_pkg;

  // ----------------------------------------------------------
  // redirect source, driven by the controller with pc_set
  // ----------------------------------------------------------
  typedef enum logic [3:0] {
    PC_BOOT      = 4'b0000, // boot address, also inits mtvec
    PC_FENCEI    = 4'b0001, // instruction after the one in ID
    PC_JUMP      = 4'b0010, // jump target resolved in ID
    PC_BRANCH    = 4'b0011, // branch target resolved in EX
    PC_EXCEPTION = 4'b0100, // trap or debug entry
    PC_MRET      = 4'b0101, // return from machine trap
    PC_URET      = 4'b0110, // return from user trap
    PC_DRET      = 4'b0111  // return from debug mode
  } pc_mux_e;

  // ----------------------------------------------------------
  // exception target, only looked at for PC_EXCEPTION
  // ----------------------------------------------------------
  typedef enum logic [2:0] {
    EXC_PC_EXCEPTION = 3'b000, // synchronous exception, base only
    EXC_PC_IRQ       = 3'b001, // vectored interrupt
    EXC_PC_DBD       = 3'b010, // debug halt request
    EXC_PC_DBE       = 3'b011  // exception while in debug mode
  } exc_pc_mux_e;

  // privilege level whose trap vector is taken
  typedef enum logic [1:0] {
    TRAP_MACHINE = 2'b00,
    TRAP_USER    = 2'b01
  } trap_mux_e;

endpackage

//--- if_data_pkg.sv
// ----------------------------------------------------------
// address and bundle types shared across the fetch stage
// trap bases are mtvec/utvec bits 31:8, 256 byte aligned
// ----------------------------------------------------------

package if_data_pkg;

  typedef logic [31:0] addr_t; // byte address

  // ----------------------------------------------------------
  // trap vector configuration from the CSR file
  // ----------------------------------------------------------
  typedef struct packed {
    logic [23:0] m_base;  // mtvec[31:8]
    logic [23:0] u_base;  // utvec[31:8]
    logic [4:0]  m_vec;   // machine interrupt id for vectoring
    logic [4:0]  u_vec;   // user interrupt id for vectoring
  } trap_cfg_t;

  // debug module entry points
  typedef struct packed {
    addr_t halt;  // entered on debug halt
    addr_t exc;   // entered on exception in debug mode
  } dbg_addr_t;

  // ----------------------------------------------------------
  // redirect targets coming from later stages and CSRs
  // ----------------------------------------------------------
  typedef struct packed {
    addr_t boot;       // reset vector, low 2 bits ignored
    addr_t jump_id;    // jal/jalr target from ID
    addr_t branch_ex;  // taken branch target from EX
    addr_t mepc;
    addr_t uepc;
    addr_t depc;
  } redir_tgt_t;

  // IF/ID pipeline word, valid travels beside it
  typedef struct packed {
    logic [31:0] instr;          // raw word, not decompressed
    addr_t       pc;             // address of instr
    logic        is_compressed;  // 16 bit encoding
    logic        illegal_c;      // all-zero 16 bit word
  } if_id_t;

endpackage

//--- if_stage.f
if_ctrl_pkg.sv
if_data_pkg.sv
exc_pc_sel.sv
next_pc_sel.sv
fetch_pipe.sv
if_stage.sv
tb_if_stage.sv

//--- if_stage.sv
// ----------------------------------------------------------
// instruction fetch stage top, wiring only
// fetch source must drop its word and restart while branch_o
// ----------------------------------------------------------

module if_stage
  import if_ctrl_pkg::*, if_data_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // trap entry
  input  trap_cfg_t   trap_cfg_i,
  input  trap_mux_e   trap_mux_i,
  input  exc_pc_mux_e exc_pc_mux_i,
  input  dbg_addr_t   dbg_addr_i,
  // redirect
  input  redir_tgt_t  redir_tgt_i,
  input  pc_mux_e     pc_mux_i,
  input  logic        pc_set_i,
  // fetch source and pipeline control
  input  logic        req_i,
  input  logic        fetch_valid_i,
  input  logic [31:0] fetch_rdata_i,
  input  logic        id_ready_i,
  input  logic        halt_if_i,
  input  logic        clear_instr_valid_i,
  output logic        fetch_ready_o,
  output logic        branch_o,
  output addr_t       branch_addr_o,
  // to ID
  output logic        instr_valid_id_o,
  output if_id_t      if_id_o,
  // status
  output addr_t       pc_if_o,
  output logic        csr_mtvec_init_o,
  output logic        perf_imiss_o
);

  addr_t exc_pc;      // trap or debug entry
  addr_t branch_addr; // redirect target, halfword aligned
  addr_t pc_id;       // pc held in ID, for fence.i

  exc_pc_sel i_exc_pc_sel (
    .trap_cfg_i   (trap_cfg_i),
    .trap_mux_i   (trap_mux_i),
    .exc_pc_mux_i (exc_pc_mux_i),
    .dbg_addr_i   (dbg_addr_i),
    .exc_pc_o     (exc_pc)
  );

  next_pc_sel i_next_pc_sel (
    .pc_mux_i         (pc_mux_i),
    .pc_set_i         (pc_set_i),
    .redir_tgt_i      (redir_tgt_i),
    .exc_pc_i         (exc_pc),
    .pc_id_i          (pc_id),
    .branch_addr_o    (branch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  // ----------------------------------------------------------
  // fetch pc and IF/ID register
  // ----------------------------------------------------------
  fetch_pipe i_fetch_pipe (
    .clk                 (clk),
    .rst_n               (rst_n),
    .req_i               (req_i),
    .pc_set_i            (pc_set_i),
    .fetch_valid_i       (fetch_valid_i),
    .fetch_rdata_i       (fetch_rdata_i),
    .id_ready_i          (id_ready_i),
    .halt_if_i           (halt_if_i),
    .clear_instr_valid_i (clear_instr_valid_i),
    .branch_addr_i       (branch_addr),
    .fetch_ready_o       (fetch_ready_o),
    .branch_o            (branch_o),
    .perf_imiss_o        (perf_imiss_o),
    .instr_valid_id_o    (instr_valid_id_o),
    .if_id_o             (if_id_o),
    .pc_if_o             (pc_if_o),
    .pc_id_o             (pc_id)
  );

  assign branch_addr_o = branch_addr; // restart address for the source

endmodule

//--- next_pc_sel.sv
// ----------------------------------------------------------
// redirect address mux, purely combinational
// result always halfword aligned, bit 0 forced low
// ----------------------------------------------------------

module next_pc_sel
  import if_ctrl_pkg::*, if_data_pkg::*;
(
  input  pc_mux_e    pc_mux_i,        // redirect source
  input  logic       pc_set_i,        // redirect taken this cycle
  input  redir_tgt_t redir_tgt_i,     // targets from ID, EX and CSRs
  input  addr_t      exc_pc_i,        // trap or debug entry
  input  addr_t      pc_id_i,         // pc of instruction in ID
  output addr_t      branch_addr_o,   // new fetch address
  output logic       csr_mtvec_init_o // boot redirect, CSR file loads mtvec
);

  addr_t sel_addr; // mux result before halfword alignment

  // ----------------------------------------------------------
  // source select
  // ----------------------------------------------------------
  always_comb begin
    case (pc_mux_i)
      PC_BOOT:      sel_addr = {redir_tgt_i.boot[31:2], 2'b00};
      PC_JUMP:      sel_addr = redir_tgt_i.jump_id;
      PC_BRANCH:    sel_addr = redir_tgt_i.branch_ex;
      PC_EXCEPTION: sel_addr = exc_pc_i;
      PC_MRET:      sel_addr = redir_tgt_i.mepc;  // back to trapped instruction
      PC_URET:      sel_addr = redir_tgt_i.uepc;
      PC_DRET:      sel_addr = redir_tgt_i.depc;  // leave debug mode
      PC_FENCEI:    sel_addr = pc_id_i + 32'd4;   // refetch after fence.i
      default:      sel_addr = redir_tgt_i.boot;  // unused codes restart at boot
    endcase
  end

  assign branch_addr_o = {sel_addr[31:1], 1'b0}; // no byte-aligned fetch

  // mtvec is reloaded only when booting
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

//--- tb_if_stage.sv
// ----------------------------------------------------------
// random testbench for if_stage, seed 14, checked at negedge
// the offered word always starts at pc_if_o, no real memory
// ----------------------------------------------------------

module tb_if_stage
  import if_ctrl_pkg::*, if_data_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_CYCLES     = 2000;
  localparam int RESET_CYCLES   = 8;
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + RESET_CYCLES + 100;

  logic        clk, rst_n;
  trap_cfg_t   trap_cfg_i;
  trap_mux_e   trap_mux_i;
  exc_pc_mux_e exc_pc_mux_i;
  dbg_addr_t   dbg_addr_i;
  redir_tgt_t  redir_tgt_i;
  pc_mux_e     pc_mux_i;
  logic        pc_set_i, req_i, fetch_valid_i, id_ready_i, halt_if_i, clear_instr_valid_i;
  logic [31:0] fetch_rdata_i;
  logic        fetch_ready_o, branch_o, instr_valid_id_o, csr_mtvec_init_o, perf_imiss_o;
  addr_t       branch_addr_o, pc_if_o;
  if_id_t      if_id_o;

  // reference state, mirrors the registers of the DUT
  addr_t  m_pc;
  if_id_t m_if_id;
  logic   m_valid;
  int     cycle_cnt;
  int     seed_ret;

  if_stage i_if_stage (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  // ----------------------------------------------------------
  // failure reporting
  // ----------------------------------------------------------
  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      $display("Fail at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_if_id(input string name, input if_id_t exp, input if_id_t act);
    if (exp !== act) begin
      $display("Fail at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Fail at %0t ns: %s expected %b, actual %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  function automatic addr_t model_exc_pc(trap_cfg_t cfg, trap_mux_e tmux, exc_pc_mux_e emux,
                                         dbg_addr_t dbg);
    addr_t      base;
    logic [4:0] idx;
    if (tmux == TRAP_USER) begin // unknown modes fall back to machine
      base = {8'h00, cfg.u_base} << 8;
      idx  = cfg.u_vec;
    end else begin
      base = {8'h00, cfg.m_base} << 8;
      idx  = cfg.m_vec;
    end
    case (emux)
      EXC_PC_IRQ: return base + {27'd0, idx} * 32'd4; // one word per interrupt slot
      EXC_PC_DBD: return dbg.halt & 32'hFFFF_FFFC;
      EXC_PC_DBE: return dbg.exc & 32'hFFFF_FFFC;
      default:    return base;
    endcase
  endfunction

  function automatic addr_t model_branch_addr(redir_tgt_t tgt, pc_mux_e sel, addr_t exc,
                                              addr_t pc_id);
    addr_t a;
    case (sel)
      PC_BOOT:      a = tgt.boot & 32'hFFFF_FFFC;
      PC_JUMP:      a = tgt.jump_id;
      PC_BRANCH:    a = tgt.branch_ex;
      PC_EXCEPTION: a = exc;
      PC_MRET:      a = tgt.mepc;
      PC_URET:      a = tgt.uepc;
      PC_DRET:      a = tgt.depc;
      PC_FENCEI:    a = pc_id + 32'd4; // next after the word in ID
      default:      a = tgt.boot;
    endcase
    return a & 32'hFFFF_FFFE; // halfword aligned
  endfunction

  function automatic logic model_accept();
    return req_i & fetch_valid_i & id_ready_i & ~halt_if_i & ~pc_set_i;
  endfunction

  function automatic addr_t model_target();
    addr_t exc;
    exc = model_exc_pc(trap_cfg_i, trap_mux_i, exc_pc_mux_i, dbg_addr_i);
    return model_branch_addr(redir_tgt_i, pc_mux_i, exc, m_if_id.pc);
  endfunction

  // ----------------------------------------------------------
  // stimulus, checks and model step
  // ----------------------------------------------------------
  task automatic drive_random();
    logic [31:0] word;
    trap_cfg_t   cfg;
    logic [31:0] rnd;
    word = $urandom;
    if ($urandom % 16 == 0) word[15:0] = 16'h0000; // hit illegal compressed now and then
    rnd         = $urandom;
    cfg.m_base  = rnd[23:0];
    cfg.m_vec   = rnd[28:24];
    rnd         = $urandom;
    cfg.u_base  = rnd[23:0];
    cfg.u_vec   = rnd[28:24];
    rnd         = $urandom;
    pc_set_i            <= ($urandom % 100) < 15;
    fetch_valid_i       <= ($urandom % 100) < 70;
    req_i               <= ($urandom % 100) < 90;
    id_ready_i          <= rnd[0] | rnd[1]; // ready about 3 of 4 cycles
    halt_if_i           <= (rnd[4:2] == 3'd0);
    clear_instr_valid_i <= (rnd[7:5] == 3'd0);
    fetch_rdata_i       <= word;
    pc_mux_i            <= pc_mux_e'(rnd[11:8] & 4'h7);
    exc_pc_mux_i        <= exc_pc_mux_e'(rnd[14:12] & 3'h3);
    trap_mux_i          <= trap_mux_e'(rnd[16:15]); // includes the two unnamed codes
    trap_cfg_i          <= cfg;
    dbg_addr_i          <= {$urandom, $urandom};
    redir_tgt_i         <= {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom};
  endtask

  task automatic check_outputs();
    check_bit("fetch_ready_o", model_accept(), fetch_ready_o);
    check_bit("branch_o", pc_set_i, branch_o);
    check_addr("branch_addr_o", model_target(), branch_addr_o);
    check_bit("csr_mtvec_init_o", pc_set_i & (pc_mux_i == PC_BOOT), csr_mtvec_init_o);
    check_bit("perf_imiss_o", ~fetch_valid_i & ~pc_set_i, perf_imiss_o);
    check_bit("instr_valid_id_o", m_valid, instr_valid_id_o);
    check_if_id("if_id_o", m_if_id, if_id_o);
    check_addr("pc_if_o", m_pc, pc_if_o);
  endtask

  // state after the coming rising edge, inputs are stable now
  task automatic step_model();
    logic is_c;
    is_c = (fetch_rdata_i[1:0] != 2'b11);
    if (model_accept()) begin
      m_valid               = 1'b1;
      m_if_id.instr         = fetch_rdata_i;
      m_if_id.pc            = m_pc;
      m_if_id.is_compressed = is_c;
      m_if_id.illegal_c     = is_c & (fetch_rdata_i[15:0] == 16'h0000);
      m_pc                  = m_pc + (is_c ? 32'd2 : 32'd4);
    end else if (clear_instr_valid_i) begin
      m_valid = 1'b0;
    end
    if (pc_set_i) m_pc = model_target();
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  initial begin
    seed_ret  = $urandom(14);
    cycle_cnt = 0;
    m_pc      = '0;
    m_if_id   = '0;
    m_valid   = 1'b0;
    rst_n = 1'b0;
    trap_cfg_i = '0;
    trap_mux_i = TRAP_MACHINE;
    exc_pc_mux_i = EXC_PC_EXCEPTION;
    dbg_addr_i = '0;
    redir_tgt_i = '0;
    pc_mux_i = PC_BOOT;
    pc_set_i = 1'b0;
    req_i = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_rdata_i = '0;
    id_ready_i = 1'b0;
    halt_if_i = 1'b0;
    clear_instr_valid_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("instr_valid_id_o", 1'b0, instr_valid_id_o); // reset state
    check_if_id("if_id_o", '0, if_id_o);
    check_addr("pc_if_o", '0, pc_if_o);
    for (int n = 0; n < NUM_CYCLES; n++) begin
      @(posedge clk);
      drive_random();
      @(negedge clk);
      check_outputs();
      step_model();
    end
    $display("TEST OK");
    $finish;
  end

endmodule
